/* alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_flush,
  input  logic                   i_iss_valid,
  input  alu_sched_pkg::alu_op_t i_iss_op,
  input  alu_sched_pkg::tag_t    i_iss_src0_tag,
  input  alu_sched_pkg::tag_t    i_iss_src1_tag,
  input  alu_sched_pkg::tag_t    i_iss_dst,
  input  logic                   i_ld_wr_valid,
  input  alu_sched_pkg::tag_t    i_ld_wr_tag,
  input  alu_sched_pkg::data_t   i_ld_wr_data,
  wakeup_if.source               alu_wake,
  output logic                   o_wb_valid,
  output alu_sched_pkg::tag_t    o_wb_tag,
  output alu_sched_pkg::data_t   o_wb_data
);

  localparam int NUM_REGS = 2 ** alu_sched_pkg::TAG_W;

  alu_sched_pkg::data_t r_regs [NUM_REGS];
  alu_sched_pkg::data_t w_a;
  alu_sched_pkg::data_t w_b;
  alu_sched_pkg::data_t w_result;
  logic                 w_wr_en;

  // ------------------------------------------------------------
  // Operand read, tag 0 is the zero register
  // ------------------------------------------------------------
  assign w_a = (i_iss_src0_tag == '0) ? '0 :
               (i_ld_wr_valid && i_ld_wr_tag == i_iss_src0_tag) ? i_ld_wr_data :  // Load bypass
               r_regs[i_iss_src0_tag];
  assign w_b = (i_iss_src1_tag == '0) ? '0 :
               (i_ld_wr_valid && i_ld_wr_tag == i_iss_src1_tag) ? i_ld_wr_data :
               r_regs[i_iss_src1_tag];

  always_comb begin
    case (i_iss_op)
      alu_sched_pkg::ADD: w_result = w_a + w_b;
      alu_sched_pkg::SUB: w_result = w_a - w_b;
      alu_sched_pkg::AND: w_result = w_a & w_b;
      alu_sched_pkg::OR:  w_result = w_a | w_b;
      alu_sched_pkg::XOR: w_result = w_a ^ w_b;
      alu_sched_pkg::SLL: w_result = w_a << w_b[4:0];
      alu_sched_pkg::SRL: w_result = w_a >> w_b[4:0];
      default: begin   // SLT, signed
        w_result = {{(alu_sched_pkg::DATA_W-1){1'b0}}, $signed(w_a) < $signed(w_b)};
      end
    endcase
  end

  assign w_wr_en = i_iss_valid & ~i_flush;

  // ------------------------------------------------------------
  // Register file and writeback stage
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r_regs[i] <= '0;
      end
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= w_wr_en;
      if (i_ld_wr_valid && i_ld_wr_tag != '0) r_regs[i_ld_wr_tag] <= i_ld_wr_data;
      if (w_wr_en && i_iss_dst != '0)         r_regs[i_iss_dst]   <= w_result;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_iss_valid) begin
      o_wb_tag  <= i_iss_dst;
      o_wb_data <= w_result;
    end
  end

  // Result is certain once in issue, dependents may pick now
  assign alu_wake.valid  = i_iss_valid;
  assign alu_wake.tag    = i_iss_dst;
  assign alu_wake.spec   = 1'b0;
  assign alu_wake.cancel = 1'b0;

endmodule

/* alu_issue_queue.sv */
`timescale 1ns/1ps

module alu_issue_queue #(
  parameter int NUM_ENTRIES = 4
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_flush,
  input  logic                   i_disp_valid,
  input  alu_sched_pkg::alu_op_t i_disp_op,
  input  logic                   i_disp_src0_valid,
  input  alu_sched_pkg::tag_t    i_disp_src0_tag,
  input  logic                   i_disp_src1_valid,
  input  alu_sched_pkg::tag_t    i_disp_src1_tag,
  input  alu_sched_pkg::tag_t    i_disp_dst,
  output logic                   o_disp_ready,
  wakeup_if.listener             alu_wake,
  wakeup_if.listener             ld_wake,
  output logic                   o_iss_valid,
  output alu_sched_pkg::alu_op_t o_iss_op,
  output alu_sched_pkg::tag_t    o_iss_src0_tag,
  output alu_sched_pkg::tag_t    o_iss_src1_tag,
  output alu_sched_pkg::tag_t    o_iss_dst
);

  localparam int NUM_TAGS = 2 ** alu_sched_pkg::TAG_W;

  logic [NUM_ENTRIES-1:0] w_valid;
  logic [NUM_ENTRIES-1:0] w_ready;
  logic [NUM_ENTRIES-1:0] w_put;
  logic [NUM_ENTRIES-1:0] w_grant;
  logic                   w_grant_valid;
  alu_sched_pkg::entry_t  w_entries [NUM_ENTRIES];
  alu_sched_pkg::age_t    w_ages [NUM_ENTRIES];
  alu_sched_pkg::entry_t  w_put_data;
  alu_sched_pkg::entry_t  w_pick;
  logic                   w_disp_fire;
  logic [1:0]             w_src_ready;
  logic                   w_ld_arrive;
  logic                   w_iss_kill;
  alu_sched_pkg::age_t    r_age;
  logic [NUM_TAGS-1:0]    r_busy;      // Tags whose value is still on its way
  logic                   r_ld_valid;
  alu_sched_pkg::tag_t    r_ld_tag;
  logic                   r_iss_valid;

  assign o_disp_ready = ~(&w_valid) & ~i_flush;
  assign w_disp_fire  = i_disp_valid & o_disp_ready;
  assign w_ld_arrive  = r_ld_valid & ~ld_wake.cancel;   // Load data on the write port now

  // ------------------------------------------------------------
  // Allocation, lowest free entry wins
  // ------------------------------------------------------------
  always_comb begin
    w_put = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!w_valid[i]) begin
        w_put    = '0;
        w_put[i] = w_disp_fire;
      end
    end
  end

  // Ready unless busy or being announced by a load this cycle
  assign w_src_ready[0] =
    (~r_busy[i_disp_src0_tag] & ~(ld_wake.valid & (ld_wake.tag == i_disp_src0_tag))) |
    (w_ld_arrive & (r_ld_tag == i_disp_src0_tag));
  assign w_src_ready[1] =
    (~r_busy[i_disp_src1_tag] & ~(ld_wake.valid & (ld_wake.tag == i_disp_src1_tag))) |
    (w_ld_arrive & (r_ld_tag == i_disp_src1_tag));

  always_comb begin
    w_put_data              = '0;
    w_put_data.valid        = 1'b1;
    w_put_data.op           = i_disp_op;
    w_put_data.src[0].valid = i_disp_src0_valid;
    w_put_data.src[0].tag   = i_disp_src0_tag;
    w_put_data.src[0].ready = w_src_ready[0];
    w_put_data.src[1].valid = i_disp_src1_valid;
    w_put_data.src[1].tag   = i_disp_src1_tag;
    w_put_data.src[1].ready = w_src_ready[1];
    w_put_data.dst          = i_disp_dst;
    w_put_data.age          = r_age;
  end

  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    iq_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_flush       (i_flush),
      .i_put         (w_put[i]),
      .i_put_data    (w_put_data),
      .i_picked      (w_grant[i]),
      .alu_wake      (alu_wake),
      .ld_wake       (ld_wake),
      .o_entry_valid (w_valid[i]),
      .o_entry_ready (w_ready[i]),
      .o_entry       (w_entries[i])
    );
    assign w_ages[i] = w_entries[i].age;
  end

  iq_picker #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_picker (
    .i_ready       (w_ready),
    .i_ages        (w_ages),
    .o_grant       (w_grant),
    .o_grant_valid (w_grant_valid)
  );

  always_comb begin
    w_pick = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (w_grant[i]) begin
        w_pick = w_entries[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Busy table, age counter and issue stage
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_age       <= '0;
      r_busy      <= '0;
      r_ld_valid  <= 1'b0;
      r_iss_valid <= 1'b0;
    end else begin
      r_ld_valid  <= ld_wake.valid;
      r_iss_valid <= w_grant_valid & ~i_flush;
      if (w_disp_fire) r_age <= r_age + 1'b1;
      if (i_flush) begin
        r_busy <= '0;
      end else begin
        if (alu_wake.valid) r_busy[alu_wake.tag] <= 1'b0;
        if (w_ld_arrive)    r_busy[r_ld_tag]     <= 1'b0;
        if (ld_wake.valid)  r_busy[ld_wake.tag]  <= 1'b1;
        if (w_disp_fire)    r_busy[i_disp_dst]   <= 1'b1;
      end
    end
  end

  // Invalid sources go out as tag 0, the zero register
  always_ff @(posedge i_clk) begin
    r_ld_tag <= ld_wake.tag;
    if (w_grant_valid) begin
      o_iss_op       <= w_pick.op;
      o_iss_src0_tag <= w_pick.src[0].valid ? w_pick.src[0].tag : '0;
      o_iss_src1_tag <= w_pick.src[1].valid ? w_pick.src[1].tag : '0;
      o_iss_dst      <= w_pick.dst;
    end
  end

  // Operation read a load that just got cancelled, entry replays
  assign w_iss_kill  = ld_wake.cancel & r_ld_valid &
                       ((o_iss_src0_tag == r_ld_tag) | (o_iss_src1_tag == r_ld_tag));
  assign o_iss_valid = r_iss_valid & ~w_iss_kill;

endmodule

/* alu_sched_pkg.sv */
package alu_sched_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int TAG_W  = 5;   // 32 physical registers
  localparam int DATA_W = 32;
  localparam int AGE_W  = 4;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [AGE_W-1:0]  age_t;    // Dispatch sequence, compared with wrap

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    SLT = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    INIT   = 2'd0,   // Free
    WAIT   = 2'd1,   // Holding, operands pending
    ISSUED = 2'd2,   // Sent to issue stage, may still replay
    CLEAR  = 2'd3    // Done, frees next cycle
  } sched_state_t;

  // ------------------------------------------------------------
  // Scheduler entry
  // ------------------------------------------------------------
  typedef struct packed {
    logic       valid;
    tag_t       tag;
    logic       ready;        // Value is in the register file
    logic [1:0] spec_ready;   // Load wakeup history, bit 0 is last cycle
  } src_t;

  typedef struct packed {
    logic            valid;
    alu_op_t         op;
    src_t [1:0]      src;
    tag_t            dst;
    age_t            age;
  } entry_t;

endpackage

/* alu_sched_top.sv */
`timescale 1ns/1ps

module alu_sched_top #(
  parameter int NUM_ENTRIES = 4
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_flush,
  input  logic                   i_disp_valid,
  input  alu_sched_pkg::alu_op_t i_disp_op,
  input  logic                   i_disp_src0_valid,
  input  alu_sched_pkg::tag_t    i_disp_src0_tag,
  input  logic                   i_disp_src1_valid,
  input  alu_sched_pkg::tag_t    i_disp_src1_tag,
  input  alu_sched_pkg::tag_t    i_disp_dst,
  output logic                   o_disp_ready,
  input  logic                   i_ld_wake_valid,
  input  alu_sched_pkg::tag_t    i_ld_wake_tag,
  input  logic                   i_ld_cancel,
  input  logic                   i_ld_wr_valid,
  input  alu_sched_pkg::tag_t    i_ld_wr_tag,
  input  alu_sched_pkg::data_t   i_ld_wr_data,
  output logic                   o_wb_valid,
  output alu_sched_pkg::tag_t    o_wb_tag,
  output alu_sched_pkg::data_t   o_wb_data
);

  logic                   w_iss_valid;
  alu_sched_pkg::alu_op_t w_iss_op;
  alu_sched_pkg::tag_t    w_iss_src0_tag;
  alu_sched_pkg::tag_t    w_iss_src1_tag;
  alu_sched_pkg::tag_t    w_iss_dst;

  wakeup_if alu_wake ();
  wakeup_if ld_wake ();

  // Early load wakeup, always speculative
  assign ld_wake.valid  = i_ld_wake_valid;
  assign ld_wake.tag    = i_ld_wake_tag;
  assign ld_wake.spec   = 1'b1;
  assign ld_wake.cancel = i_ld_cancel;

  alu_issue_queue #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_queue (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_flush           (i_flush),
    .i_disp_valid      (i_disp_valid),
    .i_disp_op         (i_disp_op),
    .i_disp_src0_valid (i_disp_src0_valid),
    .i_disp_src0_tag   (i_disp_src0_tag),
    .i_disp_src1_valid (i_disp_src1_valid),
    .i_disp_src1_tag   (i_disp_src1_tag),
    .i_disp_dst        (i_disp_dst),
    .o_disp_ready      (o_disp_ready),
    .alu_wake          (alu_wake),
    .ld_wake           (ld_wake),
    .o_iss_valid       (w_iss_valid),
    .o_iss_op          (w_iss_op),
    .o_iss_src0_tag    (w_iss_src0_tag),
    .o_iss_src1_tag    (w_iss_src1_tag),
    .o_iss_dst         (w_iss_dst)
  );

  alu_exec u_exec (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_flush        (i_flush),
    .i_iss_valid    (w_iss_valid),
    .i_iss_op       (w_iss_op),
    .i_iss_src0_tag (w_iss_src0_tag),
    .i_iss_src1_tag (w_iss_src1_tag),
    .i_iss_dst      (w_iss_dst),
    .i_ld_wr_valid  (i_ld_wr_valid),
    .i_ld_wr_tag    (i_ld_wr_tag),
    .i_ld_wr_data   (i_ld_wr_data),
    .alu_wake       (alu_wake),
    .o_wb_valid     (o_wb_valid),
    .o_wb_tag       (o_wb_tag),
    .o_wb_data      (o_wb_data)
  );

endmodule

/* filelist.f */
alu_sched_pkg.sv
wakeup_if.sv
iq_entry.sv
iq_picker.sv
alu_issue_queue.sv
alu_exec.sv
alu_sched_top.sv
tb_alu_sched.sv

/* iq_entry.sv */
`timescale 1ns/1ps

module iq_entry (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,
  input  logic                  i_put,
  input  alu_sched_pkg::entry_t i_put_data,
  input  logic                  i_picked,
  wakeup_if.listener            alu_wake,
  wakeup_if.listener            ld_wake,
  output logic                  o_entry_valid,
  output logic                  o_entry_ready,
  output alu_sched_pkg::entry_t o_entry
);

  alu_sched_pkg::sched_state_t r_state;
  alu_sched_pkg::sched_state_t w_state_next;
  alu_sched_pkg::entry_t       r_entry;
  alu_sched_pkg::entry_t       w_entry_next;
  alu_sched_pkg::entry_t       w_base;     // Entry the broadcasts apply to
  logic [1:0]                  w_sure_hit;
  logic [1:0]                  w_spec_hit;
  logic [1:0]                  w_usable;
  logic                        w_cancel;
  logic                        w_replay;

  // Incoming instruction snoops broadcasts in its dispatch cycle too
  assign w_base   = (r_state == alu_sched_pkg::INIT) ? i_put_data : r_entry;
  assign w_cancel = alu_wake.cancel | ld_wake.cancel;

  // ------------------------------------------------------------
  // Tag match against both broadcasts
  // ------------------------------------------------------------
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      w_sure_hit[s] = w_base.src[s].valid &
        ((alu_wake.valid & ~alu_wake.spec & (alu_wake.tag == w_base.src[s].tag)) |
         (ld_wake.valid  & ~ld_wake.spec  & (ld_wake.tag  == w_base.src[s].tag)));
      w_spec_hit[s] = w_base.src[s].valid &
        ((alu_wake.valid & alu_wake.spec & (alu_wake.tag == w_base.src[s].tag)) |
         (ld_wake.valid  & ld_wake.spec  & (ld_wake.tag  == w_base.src[s].tag)));
      w_usable[s] = ~r_entry.src[s].valid | r_entry.src[s].ready |
                    w_sure_hit[s] | w_spec_hit[s] |
                    (r_entry.src[s].spec_ready[0] & ~w_cancel);  // Load data lands now
    end
  end

  // Issued on a load that is now cancelled
  assign w_replay = w_cancel &
                    ((r_entry.src[0].valid & r_entry.src[0].spec_ready[0]) |
                     (r_entry.src[1].valid & r_entry.src[1].spec_ready[0]));

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    w_entry_next = w_base;
    for (int s = 0; s < 2; s++) begin
      w_entry_next.src[s].ready = w_base.src[s].ready | w_sure_hit[s] |
                                  (w_base.src[s].spec_ready[0] & ~w_cancel);
      w_entry_next.src[s].spec_ready = {w_base.src[s].spec_ready[0], w_spec_hit[s]};
    end

    case (r_state)
      alu_sched_pkg::INIT: begin
        if (i_put) begin
          w_state_next = alu_sched_pkg::WAIT;
        end else begin
          w_entry_next = r_entry;
        end
      end
      alu_sched_pkg::WAIT: begin
        if (o_entry_ready && i_picked) begin
          w_state_next = alu_sched_pkg::ISSUED;
        end
      end
      alu_sched_pkg::ISSUED: begin
        if (w_replay) begin
          w_state_next = alu_sched_pkg::WAIT;
          w_entry_next.src[0].spec_ready = 2'b00;
          w_entry_next.src[1].spec_ready = 2'b00;
        end else begin
          w_state_next = alu_sched_pkg::CLEAR;
        end
      end
      default: begin   // CLEAR
        w_state_next = alu_sched_pkg::INIT;
        w_entry_next.valid = 1'b0;
      end
    endcase

    if (i_flush) begin
      w_state_next = alu_sched_pkg::INIT;
      w_entry_next.valid = 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= alu_sched_pkg::INIT;
      r_entry <= '0;
    end else begin
      r_state <= w_state_next;
      r_entry <= w_entry_next;
    end
  end

  assign o_entry_valid = r_entry.valid;
  assign o_entry_ready = (r_state == alu_sched_pkg::WAIT) & (&w_usable);
  assign o_entry       = r_entry;

endmodule

/* iq_picker.sv */
`timescale 1ns/1ps

module iq_picker #(
  parameter int NUM_ENTRIES = 4
) (
  input  logic [NUM_ENTRIES-1:0] i_ready,
  input  alu_sched_pkg::age_t    i_ages [NUM_ENTRIES],
  output logic [NUM_ENTRIES-1:0] o_grant,
  output logic                   o_grant_valid
);

  // a was dispatched before b, ages live within half the counter range
  function automatic logic older(input alu_sched_pkg::age_t a,
                                 input alu_sched_pkg::age_t b);
    alu_sched_pkg::age_t diff;
    diff = a - b;
    return diff[alu_sched_pkg::AGE_W-1];
  endfunction

  // Each ready entry loses to any older ready entry
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      o_grant[i] = i_ready[i];
      for (int j = 0; j < NUM_ENTRIES; j++) begin
        if (j != i && i_ready[j] && older(i_ages[j], i_ages[i])) begin
          o_grant[i] = 1'b0;
        end
      end
    end
  end

  assign o_grant_valid = |i_ready;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_alu_sched -o sim_alu_sched
./obj_dir/sim_alu_sched 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

/* tb_alu_sched.sv */
`timescale 1ns/1ps

module tb_alu_sched;

  localparam int NUM_ENTRIES = 4;
  localparam int NUM_DISP    = 1500;
  localparam int CYCLE_LIMIT = 20000;   // About 13 cycles per dispatch
  localparam int AGE_SPAN    = 7;       // Ages in the queue stay within wrap range

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_flush;
  logic                   i_disp_valid;
  alu_sched_pkg::alu_op_t i_disp_op;
  logic                   i_disp_src0_valid;
  alu_sched_pkg::tag_t    i_disp_src0_tag;
  logic                   i_disp_src1_valid;
  alu_sched_pkg::tag_t    i_disp_src1_tag;
  alu_sched_pkg::tag_t    i_disp_dst;
  logic                   o_disp_ready;
  logic                   i_ld_wake_valid;
  alu_sched_pkg::tag_t    i_ld_wake_tag;
  logic                   i_ld_cancel;
  logic                   i_ld_wr_valid;
  alu_sched_pkg::tag_t    i_ld_wr_tag;
  alu_sched_pkg::data_t   i_ld_wr_data;
  logic                   o_wb_valid;
  alu_sched_pkg::tag_t    o_wb_tag;
  alu_sched_pkg::data_t   o_wb_data;

  // Reference model with records indexed by destination tag
  alu_sched_pkg::data_t   model_reg [32];
  logic                   rec_valid [32];
  alu_sched_pkg::alu_op_t rec_op    [32];
  logic                   rec_s0v   [32];
  logic                   rec_s1v   [32];
  alu_sched_pkg::tag_t    rec_s0t   [32];
  alu_sched_pkg::tag_t    rec_s1t   [32];
  int                     rec_seq   [32];

  integer              seed = 61;
  int                  n_disp = 0;
  int                  inflight = 0;
  int                  full_seen = 0;
  int                  cancel_count = 0;
  int                  flush_count = 0;
  int                  cycle_count = 0;
  int                  ld_state = 0;    // 0 idle, 1 woken last cycle, 2 cancelled
  logic                ld_pend = 1'b0;
  logic                flush_prev = 1'b0;
  alu_sched_pkg::tag_t ld_tag = '0;
  alu_sched_pkg::tag_t last_dst = '0;

  alu_sched_top #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) DUT (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_flush           (i_flush),
    .i_disp_valid      (i_disp_valid),
    .i_disp_op         (i_disp_op),
    .i_disp_src0_valid (i_disp_src0_valid),
    .i_disp_src0_tag   (i_disp_src0_tag),
    .i_disp_src1_valid (i_disp_src1_valid),
    .i_disp_src1_tag   (i_disp_src1_tag),
    .i_disp_dst        (i_disp_dst),
    .o_disp_ready      (o_disp_ready),
    .i_ld_wake_valid   (i_ld_wake_valid),
    .i_ld_wake_tag     (i_ld_wake_tag),
    .i_ld_cancel       (i_ld_cancel),
    .i_ld_wr_valid     (i_ld_wr_valid),
    .i_ld_wr_tag       (i_ld_wr_tag),
    .i_ld_wr_data      (i_ld_wr_data),
    .o_wb_valid        (o_wb_valid),
    .o_wb_tag          (o_wb_tag),
    .o_wb_data         (o_wb_data)
  );

  always #2 i_clk = ~i_clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) report_failure("Run did not finish within the cycle limit");
  end

  function automatic int unsigned pick(input int unsigned n);
    int unsigned u;
    u = $random(seed);
    return u % n;
  endfunction

  function automatic alu_sched_pkg::data_t alu_model(input alu_sched_pkg::alu_op_t op,
                                                     input alu_sched_pkg::data_t a,
                                                     input alu_sched_pkg::data_t b);
    case (op)
      alu_sched_pkg::ADD: return a + b;
      alu_sched_pkg::SUB: return a - b;
      alu_sched_pkg::AND: return a & b;
      alu_sched_pkg::OR:  return a | b;
      alu_sched_pkg::XOR: return a ^ b;
      alu_sched_pkg::SLL: return a << b[4:0];
      alu_sched_pkg::SRL: return a >> b[4:0];
      default:            return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic is_pending(input alu_sched_pkg::tag_t t);
    return rec_valid[t] || (ld_pend && ld_tag == t);
  endfunction

  function automatic logic has_reader(input alu_sched_pkg::tag_t t);
    for (int k = 0; k < 32; k++) begin
      if (rec_valid[k] && ((rec_s0v[k] && rec_s0t[k] == t) || (rec_s1v[k] && rec_s1t[k] == t)))
        return 1'b1;
    end
    return 1'b0;
  endfunction

  // Picks a nonzero tag that nothing writes or reads and gives 0 if none
  function automatic alu_sched_pkg::tag_t find_free();
    int r;
    for (int k = 0; k < 8; k++) begin
      r = 1 + pick(31);
      if (!is_pending(r[4:0]) && !has_reader(r[4:0])) return r[4:0];
    end
    return '0;
  endfunction

  function automatic logic ages_ok();
    for (int k = 0; k < 32; k++) begin
      if (rec_valid[k] && (n_disp - rec_seq[k]) >= AGE_SPAN) return 1'b0;
    end
    return 1'b1;
  endfunction

  // ------------------------------------------------------------
  // Sampling at the falling edge
  // ------------------------------------------------------------
  task automatic observe_cycle();
    alu_sched_pkg::tag_t  t;
    alu_sched_pkg::data_t a;
    alu_sched_pkg::data_t b;
    alu_sched_pkg::data_t exp_data;
    t = o_wb_tag;
    // Entries stay occupied through their writeback cycle
    if (!i_flush) begin
      assert (o_disp_ready == (inflight < NUM_ENTRIES))
        else report_failure($sformatf("Error: o_disp_ready = 0x%h, expected 0x%h (0x%h in flight)",
                                      o_disp_ready, (inflight < NUM_ENTRIES), inflight));
      if (!o_disp_ready) full_seen++;
    end
    if (o_wb_valid) begin
      assert (rec_valid[t])
        else report_failure($sformatf("Writeback of tag 0x%h with no instruction in flight", t));
      assert (!(rec_s0v[t] && is_pending(rec_s0t[t])) && !(rec_s1v[t] && is_pending(rec_s1t[t])))
        else report_failure("A writeback came before the result of its producer");
      a = rec_s0v[t] ? model_reg[rec_s0t[t]] : '0;
      b = rec_s1v[t] ? model_reg[rec_s1t[t]] : '0;
      exp_data = alu_model(rec_op[t], a, b);
      assert (o_wb_data == exp_data)
        else report_failure($sformatf("Error: o_wb_data = 0x%h, expected 0x%h (tag 0x%h)",
                                      o_wb_data, exp_data, t));
      model_reg[t] = exp_data;
      rec_valid[t] = 1'b0;
      inflight--;
    end
    if (flush_prev) begin
      assert (o_disp_ready == 1'b1)
        else report_failure($sformatf("Error: o_disp_ready = 0x%h after flush, expected 0x1",
                                      o_disp_ready));
    end
    if (i_disp_valid && o_disp_ready) begin   // Accepted at the coming edge
      t = i_disp_dst;
      rec_valid[t] = 1'b1;
      rec_op[t]    = i_disp_op;
      rec_s0v[t]   = i_disp_src0_valid;
      rec_s0t[t]   = i_disp_src0_tag;
      rec_s1v[t]   = i_disp_src1_valid;
      rec_s1t[t]   = i_disp_src1_tag;
      rec_seq[t]   = n_disp;
      n_disp++;
      inflight++;
      last_dst = t;
    end
    if (i_ld_wr_valid) begin
      model_reg[i_ld_wr_tag] = i_ld_wr_data;
      ld_pend = 1'b0;
    end
    if (i_ld_cancel) cancel_count++;
    flush_prev = i_flush;
    if (i_flush) begin   // Kills everything still queued or in issue
      for (int k = 0; k < 32; k++) rec_valid[k] = 1'b0;
      inflight = 0;
      flush_count++;
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus for the next cycle, on the rising edge
  // ------------------------------------------------------------
  task automatic drive_next();
    alu_sched_pkg::tag_t dst;
    alu_sched_pkg::tag_t s0;
    alu_sched_pkg::tag_t s1;
    logic                do_flush;
    int                  r;
    do_flush = 1'b0;
    // A flush is always followed by a cycle without one
    if (!ld_pend && !i_flush && n_disp < NUM_DISP && pick(250) == 0) begin
      do_flush = 1'b1;
    end
    i_flush         <= do_flush;
    i_disp_valid    <= 1'b0;
    i_ld_wake_valid <= 1'b0;
    i_ld_cancel     <= 1'b0;
    i_ld_wr_valid   <= 1'b0;
    if (ld_state == 1) begin
      if (pick(3) == 0) begin
        i_ld_cancel <= 1'b1;
        ld_state = 2;
      end else begin
        i_ld_wr_valid <= 1'b1;
        i_ld_wr_tag   <= ld_tag;
        i_ld_wr_data  <= $random(seed);
        ld_state = 0;
      end
    end else if (ld_state == 2) begin
      if (pick(2) == 0) begin   // Retry of the cancelled load
        i_ld_wake_valid <= 1'b1;
        i_ld_wake_tag   <= ld_tag;
        ld_state = 1;
      end
    end else if (!do_flush && n_disp < NUM_DISP && pick(8) == 0) begin
      dst = find_free();
      if (dst != '0) begin
        ld_pend = 1'b1;
        ld_tag  = dst;
        ld_state = 1;
        i_ld_wake_valid <= 1'b1;
        i_ld_wake_tag   <= dst;
      end
    end
    if (!do_flush && n_disp < NUM_DISP && pick(4) != 0 && ages_ok()) begin
      dst = find_free();
      if (dst != '0) begin
        r  = pick(32);
        s0 = (pick(2) == 0) ? last_dst : r[4:0];   // Favor chains
        r  = pick(32);
        s1 = r[4:0];
        if (s0 == dst) s0 = '0;
        if (s1 == dst) s1 = '0;
        r = pick(8);
        i_disp_valid      <= 1'b1;
        i_disp_op         <= alu_sched_pkg::alu_op_t'(r[2:0]);
        i_disp_src0_valid <= (pick(8) != 0);
        i_disp_src0_tag   <= s0;
        i_disp_src1_valid <= (pick(8) != 0);
        i_disp_src1_tag   <= s1;
        i_disp_dst        <= dst;
      end
    end
  endtask

  initial begin
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_flush = 1'b0;
    i_disp_valid = 1'b0;
    i_disp_op = alu_sched_pkg::ADD;
    i_disp_src0_valid = 1'b0;
    i_disp_src0_tag = '0;
    i_disp_src1_valid = 1'b0;
    i_disp_src1_tag = '0;
    i_disp_dst = '0;
    i_ld_wake_valid = 1'b0;
    i_ld_wake_tag = '0;
    i_ld_cancel = 1'b0;
    i_ld_wr_valid = 1'b0;
    i_ld_wr_tag = '0;
    i_ld_wr_data = '0;
    for (int k = 0; k < 32; k++) begin
      model_reg[k] = '0;
      rec_valid[k] = 1'b0;
    end
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    assert (o_wb_valid == 1'b0)
      else report_failure($sformatf("Error: o_wb_valid = 0x%h after reset", o_wb_valid));
    assert (o_disp_ready == 1'b1)
      else report_failure($sformatf("Error: o_disp_ready = 0x%h after reset", o_disp_ready));
    forever begin
      observe_cycle();
      if (n_disp >= NUM_DISP && inflight == 0 && !ld_pend) break;
      @(posedge i_clk);
      drive_next();
      @(negedge i_clk);
    end
    repeat (10) begin   // Drain cycles in which no stray writeback may appear
      @(posedge i_clk);
      drive_next();
      @(negedge i_clk);
      observe_cycle();
    end
    assert (full_seen > 0) else report_failure("The queue never filled up");
    assert (cancel_count > 0) else report_failure("No load wakeup was ever cancelled");
    assert (flush_count > 0) else report_failure("No flush was ever applied");
    $display("All checks passed");
    $finish;
  end

endmodule

/* wakeup_if.sv */
`timescale 1ns/1ps

// One tag broadcast. A speculative broadcast may be taken back by
// cancel one cycle after its valid
interface wakeup_if;

  logic                valid;
  alu_sched_pkg::tag_t tag;
  logic                spec;
  logic                cancel;

  modport source (
    output valid,
    output tag,
    output spec,
    output cancel
  );

  modport listener (
    input valid,
    input tag,
    input spec,
    input cancel
  );

endinterface
